// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpu_ncp
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard include/*.svh src/*.sv test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+include
src/fpu_ncp_pkg.sv
src/fpu_ncp_decode.sv
src/fpu_delay_line.sv
src/fpu_fcmp_core.sv
src/fpu_fsgn_core.sv
src/fpu_rsp_arb.sv
src/fpu_ncp_top.sv
test/tb_fpu_ncp.sv

// File: include/fpu_ncp_config.svh
`ifndef FPU_NCP_CONFIG_SVH
`define FPU_NCP_CONFIG_SVH

// Lanes computed per request.
`define FPU_NUM_LANES 2

// Width of the request tag carried to the response.
`define FPU_TAG_WIDTH 8

// Delay of the compare core from accept to output valid.
`define FPU_LATENCY_FCMP 3

// Delay of the sign core.
`define FPU_LATENCY_FSGN 1

`endif

// File: src/fpu_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    logic [DEPTH-1:0] valid_q;
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= valid_in;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_q[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[DEPTH-1];
    assign data_out  = data_q[DEPTH-1];

    // A frozen line keeps presenting the same response.
    a_hold_when_frozen: assert property (@(posedge clk) disable iff (rst)
        !enable |=> $stable(valid_out) && (!valid_out || $stable(data_out)));

endmodule

`default_nettype wire

// File: src/fpu_fcmp_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ncp_config.svh"

module fpu_fcmp_core import fpu_ncp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  fcmp_op_t op,
    input  fpu_req_t req,
    output logic     out_valid,
    input  logic     out_ready,
    output fpu_rsp_t out_data
);

    fpu_rsp_t rsp_d;

    // Sign first, then magnitude; -0 falls below +0 here.
    function automatic logic ord_lt(logic [31:0] a, logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
    endfunction

    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        logic        nan;
        logic        snan;
        logic        eq;
        logic        lt;
        rsp_d            = '0;
        rsp_d.tag        = req.tag;
        rsp_d.has_fflags = 1'b1;
        for (int i = 0; i < `FPU_NUM_LANES; i++) begin
            a    = req.dataa[i];
            b    = req.datab[i];
            nan  = fp_is_nan(a) || fp_is_nan(b);
            snan = fp_is_snan(a) || fp_is_snan(b);
            eq   = (a == b) || ((a[30:0] | b[30:0]) == 31'd0);
            lt   = ord_lt(a, b) && !eq;
            case (op)
                FCMP_FLT: begin
                    rsp_d.result[i]    = {31'd0, lt && !nan};
                    rsp_d.fflags[i].nv = nan;
                end
                FCMP_FLE: begin
                    rsp_d.result[i]    = {31'd0, (lt || eq) && !nan};
                    rsp_d.fflags[i].nv = nan;
                end
                FCMP_FEQ: begin
                    rsp_d.result[i]    = {31'd0, eq && !nan};
                    rsp_d.fflags[i].nv = snan;
                end
                // Min and max.
                default: begin
                    rsp_d.fflags[i].nv = snan;
                    if (fp_is_nan(a) && fp_is_nan(b)) begin
                        rsp_d.result[i] = FP_QNAN;
                    end else if (fp_is_nan(a)) begin
                        rsp_d.result[i] = b;
                    end else if (fp_is_nan(b)) begin
                        rsp_d.result[i] = a;
                    end else begin
                        rsp_d.result[i] = ((op == FCMP_FMIN) == ord_lt(a, b)) ? a : b;
                    end
                end
            endcase
        end
    end

    assign in_ready = !out_valid || out_ready;

    fpu_delay_line #(
        .payload_t (fpu_rsp_t),
        .DEPTH     (`FPU_LATENCY_FCMP)
    ) delay (
        .clk       (clk),
        .rst       (rst),
        .enable    (in_ready),
        .valid_in  (in_valid),
        .data_in   (rsp_d),
        .valid_out (out_valid),
        .data_out  (out_data)
    );

    a_no_accept_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |-> !(in_valid && in_ready));

endmodule

`default_nettype wire

// File: src/fpu_fsgn_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ncp_config.svh"

module fpu_fsgn_core import fpu_ncp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  fsgn_op_t  op,
    input  fpu_req_t  req,
    output logic      out_valid,
    input  logic      out_ready,
    output fsgn_rsp_t out_data
);

    fsgn_rsp_t rsp_d;

    // One-hot class mask from -inf at bit 0 up to quiet NaN at bit 9.
    function automatic logic [31:0] fclass(logic [31:0] x);
        logic       exp_ones;
        logic       exp_zero;
        logic       man_zero;
        logic [3:0] idx;
        exp_ones = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        if (exp_ones && !man_zero) begin
            idx = x[22] ? 4'd9 : 4'd8;
        end else if (exp_ones) begin
            idx = x[31] ? 4'd0 : 4'd7;
        end else if (exp_zero && man_zero) begin
            idx = x[31] ? 4'd3 : 4'd4;
        end else if (exp_zero) begin
            idx = x[31] ? 4'd2 : 4'd5;
        end else begin
            idx = x[31] ? 4'd1 : 4'd6;
        end
        return 32'd1 << idx;
    endfunction

    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        rsp_d.tag = req.tag;
        for (int i = 0; i < `FPU_NUM_LANES; i++) begin
            a = req.dataa[i];
            b = req.datab[i];
            case (op)
                FSGN_SGNJ:  rsp_d.result[i] = {b[31], a[30:0]};
                FSGN_SGNJN: rsp_d.result[i] = {~b[31], a[30:0]};
                FSGN_SGNJX: rsp_d.result[i] = {a[31] ^ b[31], a[30:0]};
                FSGN_CLASS: rsp_d.result[i] = fclass(a);
                default:    rsp_d.result[i] = a;
            endcase
        end
    end

    assign in_ready = !out_valid || out_ready;

    fpu_delay_line #(
        .payload_t (fsgn_rsp_t),
        .DEPTH     (`FPU_LATENCY_FSGN)
    ) delay (
        .clk       (clk),
        .rst       (rst),
        .enable    (in_ready),
        .valid_in  (in_valid),
        .data_in   (rsp_d),
        .valid_out (out_valid),
        .data_out  (out_data)
    );

endmodule

`default_nettype wire

// File: src/fpu_ncp_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_decode import fpu_ncp_pkg::*; (
    input  logic       valid_in,
    input  fpu_op_t    op_type,
    input  logic [2:0] frm,
    output logic       fcmp_valid,
    output logic       fsgn_valid,
    output fcmp_op_t   fcmp_op,
    output fsgn_op_t   fsgn_op,
    output logic       sel_fcmp
);

    always_comb begin
        sel_fcmp = 1'b0;
        fcmp_op  = FCMP_FLE;
        fsgn_op  = FSGN_MV;
        case (op_type)
            FPU_OP_CMP: begin
                sel_fcmp = (frm <= 3'd2);
                case (frm)
                    3'd0:    fcmp_op = FCMP_FLE;
                    3'd1:    fcmp_op = FCMP_FLT;
                    default: fcmp_op = FCMP_FEQ;
                endcase
            end
            FPU_OP_CLASS: begin
                fsgn_op = FSGN_CLASS;
            end
            // Misc group also takes the unused op code.
            default: begin
                case (frm)
                    3'd0:    fsgn_op = FSGN_SGNJ;
                    3'd1:    fsgn_op = FSGN_SGNJN;
                    3'd2:    fsgn_op = FSGN_SGNJX;
                    default: fsgn_op = FSGN_MV;
                endcase
                sel_fcmp = (frm == 3'd3) || (frm == 3'd4);
                fcmp_op  = (frm == 3'd3) ? FCMP_FMIN : FCMP_FMAX;
            end
        endcase
    end

    assign fcmp_valid = valid_in && sel_fcmp;
    assign fsgn_valid = valid_in && !sel_fcmp;

endmodule

`default_nettype wire

// File: src/fpu_ncp_pkg.sv
`default_nettype none

`include "fpu_ncp_config.svh"

package fpu_ncp_pkg;

    // Canonical quiet NaN.
    localparam logic [31:0] FP_QNAN = 32'h7FC0_0000;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [1:0] {
        FPU_OP_CMP   = 2'd0,
        FPU_OP_CLASS = 2'd1,
        FPU_OP_MISC  = 2'd2
    } fpu_op_t;

    typedef enum logic [2:0] {
        FCMP_FLE  = 3'd0,
        FCMP_FLT  = 3'd1,
        FCMP_FEQ  = 3'd2,
        FCMP_FMIN = 3'd3,
        FCMP_FMAX = 3'd4
    } fcmp_op_t;

    typedef enum logic [2:0] {
        FSGN_SGNJ  = 3'd0,
        FSGN_SGNJN = 3'd1,
        FSGN_SGNJX = 3'd2,
        FSGN_CLASS = 3'd3,
        FSGN_MV    = 3'd4
    } fsgn_op_t;

    typedef logic [`FPU_NUM_LANES-1:0][31:0] lane_word_t;
    typedef fflags_t [`FPU_NUM_LANES-1:0] lane_flags_t;

    typedef struct packed {
        logic [`FPU_TAG_WIDTH-1:0] tag;
        lane_word_t                dataa;
        lane_word_t                datab;
    } fpu_req_t;

    typedef struct packed {
        logic [`FPU_TAG_WIDTH-1:0] tag;
        lane_word_t                result;
    } fsgn_rsp_t;

    typedef struct packed {
        logic [`FPU_TAG_WIDTH-1:0] tag;
        lane_word_t                result;
        logic                      has_fflags;
        lane_flags_t               fflags;
    } fpu_rsp_t;

    function automatic logic fp_is_nan(logic [31:0] x);
        return (&x[30:23]) && (|x[22:0]);
    endfunction

    // Signaling when the top mantissa bit is clear.
    function automatic logic fp_is_snan(logic [31:0] x);
        return fp_is_nan(x) && !x[22];
    endfunction

endpackage

`default_nettype wire

// File: src/fpu_ncp_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ncp_top import fpu_ncp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_in,
    output logic       ready_in,
    input  fpu_op_t    op_type,
    input  logic [2:0] frm,
    input  fpu_req_t   req,
    output logic       valid_out,
    input  logic       ready_out,
    output fpu_rsp_t   rsp
);

    logic      fcmp_valid;
    logic      fsgn_valid;
    fcmp_op_t  fcmp_op;
    fsgn_op_t  fsgn_op;
    logic      sel_fcmp;
    logic      fcmp_ready;
    logic      fsgn_ready;
    fpu_rsp_t  fcmp_rsp;
    fsgn_rsp_t fsgn_rsp;

    logic     [1:0] arb_valid;
    logic     [1:0] arb_ready;
    fpu_rsp_t [1:0] arb_data;

    fpu_ncp_decode decode (
        .valid_in   (valid_in),
        .op_type    (op_type),
        .frm        (frm),
        .fcmp_valid (fcmp_valid),
        .fsgn_valid (fsgn_valid),
        .fcmp_op    (fcmp_op),
        .fsgn_op    (fsgn_op),
        .sel_fcmp   (sel_fcmp)
    );

    assign ready_in = sel_fcmp ? fcmp_ready : fsgn_ready;

    fpu_fcmp_core fcmp (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fcmp_valid),
        .in_ready  (fcmp_ready),
        .op        (fcmp_op),
        .req       (req),
        .out_valid (arb_valid[0]),
        .out_ready (arb_ready[0]),
        .out_data  (fcmp_rsp)
    );

    fpu_fsgn_core fsgn (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fsgn_valid),
        .in_ready  (fsgn_ready),
        .op        (fsgn_op),
        .req       (req),
        .out_valid (arb_valid[1]),
        .out_ready (arb_ready[1]),
        .out_data  (fsgn_rsp)
    );

    assign arb_data[0] = fcmp_rsp;

    // Sign core raises no flags.
    assign arb_data[1] = '{
        tag:        fsgn_rsp.tag,
        result:     fsgn_rsp.result,
        has_fflags: 1'b0,
        fflags:     '0
    };

    fpu_rsp_arb rsp_arb (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .in_data   (arb_data),
        .out_valid (valid_out),
        .out_ready (ready_out),
        .out_data  (rsp)
    );

endmodule

`default_nettype wire

// File: src/fpu_rsp_arb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rsp_arb import fpu_ncp_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic     [1:0]     in_valid,
    output logic     [1:0]     in_ready,
    input  fpu_rsp_t [1:0]     in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output fpu_rsp_t           out_data
);

    logic       last_grant;
    logic [1:0] grant;
    logic       load;

    // Output register is free or drains this cycle.
    assign load = !out_valid || out_ready;

    // On a tie the input after the last winner goes first.
    always_comb begin
        if (in_valid == 2'b11) begin
            grant = last_grant ? 2'b01 : 2'b10;
        end else begin
            grant = in_valid;
        end
    end

    assign in_ready = grant & {2{load}};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            last_grant <= 1'b0;
        end else if (load) begin
            out_valid <= |in_valid;
            if (|in_valid) begin
                last_grant <= grant[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && |in_valid) begin
            out_data <= in_data[grant[1]];
        end
    end

    a_single_grant: assert property (@(posedge clk) disable iff (rst)
        |in_valid |-> $onehot0(in_ready));

endmodule

`default_nettype wire

// File: test/tb_fpu_ncp.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_ncp_config.svh"

module tb_fpu_ncp import fpu_ncp_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int NUM_PAIRS    = 12;
    localparam int NUM_OPS      = 10;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_REQ      = NUM_PAIRS * NUM_OPS + NUM_RANDOM;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + 40 * NUM_REQ) * 8;
    localparam int NUM_TAGS     = 2 ** `FPU_TAG_WIDTH;

    // Directed operands as (a, b) pairs; lane l takes pair p + l.
    localparam logic [31:0] PAIR_A [NUM_PAIRS] = '{
        32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, 32'h0000_0000,
        32'h8000_0000, 32'h7FC0_0000, 32'hBF80_0000, 32'h7FC0_0000,
        32'h7F80_0000, 32'hFF80_0000, 32'h807F_FFFF, 32'h7FA0_0000
    };
    localparam logic [31:0] PAIR_B [NUM_PAIRS] = '{
        32'h4000_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h8000_0000,
        32'h0000_0000, 32'h3F80_0000, 32'h7F80_0001, 32'h7FA0_0000,
        32'hBF80_0000, 32'h0000_0001, 32'h0040_0000, 32'hFFC0_0000
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       valid_in;
    logic       ready_in;
    fpu_op_t    op_type;
    logic [2:0] frm;
    fpu_req_t   req;
    logic       valid_out;
    logic       ready_out;
    fpu_rsp_t   rsp;

    int checks = 0;
    int errors = 0;
    int cycle = 0;
    int outstanding = 0;
    logic timing_check = 1'b0;
    logic random_ready = 1'b0;
    logic [31:0] rng_stim = 32'd6;
    logic [31:0] rng_ready = 32'd6;
    logic [`FPU_TAG_WIDTH-1:0] next_tag = '0;

    fpu_rsp_t expected [NUM_TAGS];
    logic     pending [NUM_TAGS];
    int       accept_cycle [NUM_TAGS];
    logic [`FPU_TAG_WIDTH-1:0] cmp_order [$];
    logic [`FPU_TAG_WIDTH-1:0] sgn_order [$];

    fpu_ncp_top uut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .op_type   (op_type),
        .frm       (frm),
        .req       (req),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_nan(logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic is_snan(logic [31:0] x);
        return is_nan(x) && (x[22] == 1'b0);
    endfunction

    // Monotonic key with -0 strictly below +0.
    function automatic logic [31:0] order_key(logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [31:0] class_mask(logic [31:0] x);
        logic [31:0] m;
        int          pos;
        m = '0;
        if (x[30:23] == 8'hFF) begin
            pos = (x[22:0] == 23'd0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
        end else if (x[30:23] == 8'h00) begin
            pos = (x[22:0] == 23'd0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
        end else begin
            pos = x[31] ? 1 : 6;
        end
        m[pos] = 1'b1;
        return m;
    endfunction

    function automatic fpu_rsp_t ref_rsp(fpu_op_t op, logic [2:0] f, fpu_req_t r);
        fpu_rsp_t    e;
        logic [31:0] a;
        logic [31:0] b;
        logic        any_nan;
        logic        any_snan;
        logic        same;
        logic        less;
        e            = '0;
        e.tag        = r.tag;
        e.has_fflags = (op == FPU_OP_CMP) || (op == FPU_OP_MISC && (f == 3'd3 || f == 3'd4));
        for (int i = 0; i < `FPU_NUM_LANES; i++) begin
            a        = r.dataa[i];
            b        = r.datab[i];
            any_nan  = is_nan(a) || is_nan(b);
            any_snan = is_snan(a) || is_snan(b);
            same     = (a == b) || (a[30:0] == 31'd0 && b[30:0] == 31'd0);
            less     = !same && (order_key(a) < order_key(b));
            if (op == FPU_OP_CMP) begin
                case (f)
                    3'd0: e.result[i] = {31'd0, (less || same) && !any_nan};
                    3'd1: e.result[i] = {31'd0, less && !any_nan};
                    default: e.result[i] = {31'd0, same && !any_nan};
                endcase
                e.fflags[i].nv = (f == 3'd2) ? any_snan : any_nan;
            end else if (op == FPU_OP_CLASS) begin
                e.result[i] = class_mask(a);
            end else begin
                case (f)
                    3'd0: e.result[i] = {b[31], a[30:0]};
                    3'd1: e.result[i] = {!b[31], a[30:0]};
                    3'd2: e.result[i] = {a[31] ^ b[31], a[30:0]};
                    3'd3, 3'd4: begin
                        e.fflags[i].nv = any_snan;
                        if (is_nan(a) && is_nan(b)) begin
                            e.result[i] = 32'h7FC0_0000;
                        end else if (is_nan(a) || is_nan(b)) begin
                            e.result[i] = is_nan(a) ? b : a;
                        end else if (f == 3'd3) begin
                            e.result[i] = (order_key(a) < order_key(b)) ? a : b;
                        end else begin
                            e.result[i] = (order_key(a) > order_key(b)) ? a : b;
                        end
                    end
                    default: e.result[i] = a;
                endcase
            end
        end
        return e;
    endfunction

    function automatic logic [31:0] pool_value(logic [3:0] k);
        case (k)
            4'd0:  return 32'h0000_0000;
            4'd1:  return 32'h8000_0000;
            4'd2:  return 32'h7F80_0000;
            4'd3:  return 32'hFF80_0000;
            4'd4:  return 32'h0000_0001;
            4'd5:  return 32'h807F_FFFF;
            4'd6:  return 32'h3F80_0000;
            4'd7:  return 32'hBF80_0000;
            4'd8:  return 32'h4049_0FDB;
            4'd9:  return 32'hC000_0000;
            4'd10: return 32'h7FC0_0000;
            4'd11: return 32'hFFC0_0001;
            4'd12: return 32'h7F80_0001;
            4'd13: return 32'hFFA0_0000;
            4'd14: return 32'h3F80_0001;
            default: return 32'h0040_0000;
        endcase
    endfunction

    // Index 0..9 selects fle, flt, feq, class, sgnj, sgnjn, sgnjx, min, max, move.
    task automatic op_for_index(input int idx, input logic [31:0] r,
                                output fpu_op_t op, output logic [2:0] f);
        if (idx < 3) begin
            op = FPU_OP_CMP;
            f  = 3'(idx);
        end else if (idx == 3) begin
            op = FPU_OP_CLASS;
            f  = r[18:16];
        end else if (idx < 9) begin
            op = FPU_OP_MISC;
            f  = 3'(idx - 4);
        end else begin
            op = FPU_OP_MISC;
            f  = 3'(5 + int'(r[17:16] % 2'd3));
        end
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s: got %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // Called on a rising edge; returns on the edge that accepts.
    task automatic send_req(input fpu_op_t op, input logic [2:0] f,
                            input lane_word_t a, input lane_word_t b);
        valid_in <= 1'b1;
        op_type  <= op;
        frm      <= f;
        req      <= '{tag: next_tag, dataa: a, datab: b};
        next_tag++;
        do @(posedge clk); while (!ready_in);
        valid_in <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (outstanding != 0) @(posedge clk);
    endtask

    always @(posedge clk) begin : monitor
        fpu_rsp_t                  want;
        logic [`FPU_TAG_WIDTH-1:0] head;
        int                        lat;
        if (!rst && valid_in && ready_in) begin
            if (pending[req.tag]) begin
                errors++;
                $display("Error at %0t ns: tag %0d reused while in flight", $time, req.tag);
            end
            want                   = ref_rsp(op_type, frm, req);
            expected[req.tag]      = want;
            pending[req.tag]       = 1'b1;
            accept_cycle[req.tag]  = cycle;
            outstanding++;
            if (want.has_fflags) cmp_order.push_back(req.tag);
            else sgn_order.push_back(req.tag);
        end
        if (!rst && valid_out && ready_out) begin
            if (!pending[rsp.tag]) begin
                errors++;
                $display("Error at %0t ns: response tag %0d has no request outstanding",
                         $time, rsp.tag);
            end else begin
                want = expected[rsp.tag];
                check_value($sformatf("response tag %0d", rsp.tag), 128'(rsp), 128'(want));
                head = want.has_fflags ? cmp_order.pop_front() : sgn_order.pop_front();
                check_value("per-core order", 128'(rsp.tag), 128'(head));
                if (timing_check) begin
                    lat = want.has_fflags ? `FPU_LATENCY_FCMP + 1 : `FPU_LATENCY_FSGN + 1;
                    check_value("latency", 128'(cycle - accept_cycle[rsp.tag]), 128'(lat));
                end
                pending[rsp.tag] = 1'b0;
                outstanding--;
            end
        end
    end

    always @(posedge clk) begin
        if (random_ready) begin
            rng_ready = xorshift(rng_ready);
            ready_out <= rng_ready[5] | rng_ready[9];
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: %0d responses still missing after %0d ns", outstanding, TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        fpu_op_t    op;
        logic [2:0] f;
        lane_word_t a;
        lane_word_t b;
        rst       = 1'b1;
        valid_in  = 1'b0;
        op_type   = FPU_OP_CMP;
        frm       = 3'd0;
        req       = '0;
        ready_out = 1'b1;
        for (int t = 0; t < NUM_TAGS; t++) pending[t] = 1'b0;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) rst <= 1'b0;
            @(negedge clk);
            check_value("valid_out in reset", 128'(valid_out), 128'(0));
        end
        @(negedge clk);
        check_value("valid_out after reset", 128'(valid_out), 128'(0));
        @(posedge clk);

        // One request at a time with the output always ready.
        timing_check = 1'b1;
        for (int o = 0; o < NUM_OPS; o++) begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                op_for_index(o, 32'h0005_0000, op, f);
                for (int l = 0; l < `FPU_NUM_LANES; l++) begin
                    a[l] = PAIR_A[(p + l) % NUM_PAIRS];
                    b[l] = PAIR_B[(p + l) % NUM_PAIRS];
                end
                send_req(op, f, a, b);
                wait_idle();
            end
        end
        timing_check = 1'b0;

        // Back-to-back mixed traffic under random back-pressure.
        random_ready = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng_stim = xorshift(rng_stim);
            op_for_index(int'(rng_stim % 32'd10), rng_stim, op, f);
            for (int l = 0; l < `FPU_NUM_LANES; l++) begin
                a[l] = pool_value(rng_stim[8 + 8 * l +: 4]);
                b[l] = pool_value(rng_stim[12 + 8 * l +: 4]);
            end
            send_req(op, f, a, b);
            if (rng_stim[31:29] == 3'd0) @(posedge clk);
        end
        wait_idle();
        random_ready = 1'b0;
        @(posedge clk);
        ready_out <= 1'b1;
        repeat (10) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
